// ==== filelist.f ====
verilog/frontend_pkg.sv
verilog/pc_reg.sv
verilog/bpu.sv
verilog/instbuffer.sv
verilog/frontend_top.sv
bench/frontend_sva.sv
bench/tb_frontend_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_frontend_top -f filelist.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+10

clean:
	rm -rf obj_dir

// ==== bench/tb_frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frontend_top;

    import frontend_pkg::*;

    localparam addr_t RESET_PC    = 32'h0000_1000;
    localparam addr_t FLUSH_PC    = 32'h0000_1044;
    localparam int    TEST_CYCLES = 1500;
    localparam int    FLUSH_CYCLE = 600;
    localparam int    STALL_CYCLE = 1000;

    logic         clk;
    logic         rst_i;
    logic         stall_i;
    logic         branch_flush_i;
    addr_t        branch_actual_addr_i;
    word_t        inst_1_i;
    word_t        inst_2_i;
    logic         inst_en_1_o;
    logic         inst_en_2_o;
    addr_t        pc1_o;
    addr_t        pc2_o;
    logic         send_inst_1_en_i;
    logic         send_inst_2_en_i;
    branch_info_t branch_info1_o;
    branch_info_t branch_info2_o;
    inst_and_pc_t inst_and_pc_o;

    // Program image and the control transfers placed into it
    word_t  mem      [256];
    logic   is_cti   [256];
    logic   is_jal   [256];
    addr_t  cti_dest [256];

    // Fetch seen last cycle and answered this cycle
    addr_t  req_pc_1;
    addr_t  req_pc_2;
    logic   req_en_1;
    logic   req_en_2;

    addr_t  ref_pc;
    logic   flush_pending;
    logic   flush_checked;
    int     popped;
    int     idle_left;
    integer seed;

    frontend_top #(
        .RESET_PC (RESET_PC),
        .IB_DEPTH (8)
    ) i_frontend_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Twice the length of the main loop
    initial begin
        repeat (2 * TEST_CYCLES) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", 2 * TEST_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////
    // Error reporting
    ////////////////////////////////

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL at %0t: %s expected %h, actual %h", $time, name, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_text(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else fail_value(name, exp, act);
    endtask

    ////////////////////////////////
    // Program and reference stream
    ////////////////////////////////

    task automatic place_cti(input addr_t pc, input addr_t dest, input logic jal);
        addr_t d;
        d = dest - pc;
        if (jal) begin
            mem[pc[9:2]] = {d[20], d[10:1], d[11], d[19:12], 5'd1, OPC_JAL};
        end else begin
            mem[pc[9:2]] = {d[12], d[10:5], 5'd2, 5'd1, 3'b001, d[4:1], d[11], OPC_BRANCH};
        end
        is_cti[pc[9:2]]   = 1'b1;
        is_jal[pc[9:2]]   = jal;
        cti_dest[pc[9:2]] = dest;
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            // Plain ALU words carrying their own index
            mem[i]      = {4'h0, 8'(i), 13'h0, 7'h13};
            is_cti[i]   = 1'b0;
            is_jal[i]   = 1'b0;
            cti_dest[i] = '0;
        end
        // Forward branch, then JAL onto an odd word
        place_cti(32'h0000_100c, 32'h0000_1018, 1'b0);
        place_cti(32'h0000_1018, 32'h0000_102c, 1'b1);
        // Loop closing backward branch
        place_cti(32'h0000_1034, 32'h0000_100c, 1'b0);
        // Flush region jumps back to the start
        place_cti(32'h0000_104c, 32'h0000_1000, 1'b1);
    endtask

    // JAL always taken and a conditional branch taken when backward
    function automatic logic predict_taken(input addr_t pc);
        return is_cti[pc[9:2]] && (is_jal[pc[9:2]] || (cti_dest[pc[9:2]] < pc));
    endfunction

    task automatic check_pop(input ib_slot_t s, input branch_info_t bi, input string tag);
        logic [7:0] k;
        k = ref_pc[9:2];
        check_value({tag, ".pc"}, ref_pc, s.pc);
        check_value({tag, ".inst"}, mem[k], s.inst);
        check_value({tag, ".is_branch"}, 32'(is_cti[k]), 32'(bi.is_branch));
        check_value({tag, ".taken"}, 32'(predict_taken(ref_pc)), 32'(bi.taken));
        if (is_cti[k]) begin
            check_value({tag, ".target"}, cti_dest[k], bi.target);
        end
        // Stream restarts at FLUSH_PC, so the pc check above covers the flush
        if (flush_pending) begin
            flush_pending = 1'b0;
            flush_checked = 1'b1;
        end
        ref_pc = predict_taken(ref_pc) ? cti_dest[k] : ref_pc + 32'd4;
        popped++;
    endtask

    // Random decode side pops with long idle runs
    task automatic drive_consumer(input logic allow);
        logic [31:0] rnd;
        int          want;
        send_inst_1_en_i = 1'b0;
        send_inst_2_en_i = 1'b0;
        rnd  = $random(seed);
        want = int'(rnd[1:0]);
        if (!allow) return;
        if (idle_left > 0) begin
            idle_left--;
            return;
        end
        if (rnd[7:4] == 4'h0) begin
            idle_left = 8 + int'(rnd[12:8]);
            return;
        end
        if (want >= 1 && inst_and_pc_o.slot_1.valid) begin
            check_pop(inst_and_pc_o.slot_1, branch_info1_o, "slot_1");
            send_inst_1_en_i = 1'b1;
            if (want >= 2 && inst_and_pc_o.slot_2.valid) begin
                check_pop(inst_and_pc_o.slot_2, branch_info2_o, "slot_2");
                send_inst_2_en_i = 1'b1;
            end
        end
    endtask

    ////////////////////////////////
    // Main sequence
    ////////////////////////////////

    initial begin
        rst_i                = 1'b1;
        stall_i              = 1'b0;
        branch_flush_i       = 1'b0;
        branch_actual_addr_i = '0;
        inst_1_i             = '0;
        inst_2_i             = '0;
        send_inst_1_en_i     = 1'b0;
        send_inst_2_en_i     = 1'b0;
        req_pc_1             = '0;
        req_pc_2             = '0;
        req_en_1             = 1'b0;
        req_en_2             = 1'b0;
        ref_pc               = RESET_PC;
        flush_pending        = 1'b0;
        flush_checked        = 1'b0;
        popped               = 0;
        idle_left            = 0;
        seed                 = 32'hff9f;
        load_program();

        // Enables looked at after each reset edge
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            assert (!inst_en_1_o && !inst_en_2_o) else fail_text("fetch enabled during reset");
        end
        rst_i = 1'b0;

        for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
            @(negedge clk);
            // Synchronous memory answers the previous cycle's fetch
            if (req_en_1) inst_1_i = mem[req_pc_1[9:2]];
            if (req_en_2) inst_2_i = mem[req_pc_2[9:2]];
            if (i_frontend_top.u_frontend_sva.assert_fired) begin
                fail_text("a bound assertion fired");
            end
            branch_flush_i       = (cyc == FLUSH_CYCLE);
            branch_actual_addr_i = FLUSH_PC;
            stall_i              = (cyc >= STALL_CYCLE) && (cyc < STALL_CYCLE + 8);
            drive_consumer(!branch_flush_i);
            if (branch_flush_i) begin
                ref_pc        = FLUSH_PC;
                flush_pending = 1'b1;
            end
            #1;
            if (cyc == 0) begin
                check_value("inst_en_1_o", 32'd1, 32'(inst_en_1_o));
                check_value("inst_en_2_o", 32'd1, 32'(inst_en_2_o));
                check_value("pc1_o", RESET_PC, pc1_o);
                check_value("pc2_o", RESET_PC + 32'd4, pc2_o);
            end
            req_pc_1 = pc1_o;
            req_pc_2 = pc2_o;
            req_en_1 = inst_en_1_o;
            req_en_2 = inst_en_2_o;
        end

        if (popped >= 200 && flush_checked) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d entries popped, flush checked %0b", popped, flush_checked);
            $display("CHECKS FAILED");
            $fatal(1, "too little activity");
        end
    end

endmodule

`default_nettype wire

// ==== bench/frontend_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_sva #(
    parameter int unsigned IB_DEPTH = 8,
    localparam int         CNT_W    = $clog2(IB_DEPTH) + 1
) (
    input logic                clk,
    input logic                rst_i,
    input logic                stall_i,
    input logic                branch_flush_i,
    input logic                redirect_valid_i,
    input logic                ib_room_i,
    input logic                inst_en_1_i,
    input logic                inst_en_2_i,
    input frontend_pkg::addr_t pc1_i,
    input logic                head_valid_1_i,
    input logic                head_valid_2_i,
    input logic [CNT_W-1:0]    count_i
);

    // Set once any assertion below fails
    logic assert_fired = 1'b0;

    ////////////////////////////////
    // Fetch enables
    ////////////////////////////////

    a_hold_no_fetch: assert property (
        @(posedge clk) disable iff (rst_i)
        (stall_i || !ib_room_i) |-> (!inst_en_1_i && !inst_en_2_i)
    ) else begin
        assert_fired = 1'b1;
        $error("fetch enabled during stall or without buffer room");
    end

    // Only a flush or a redirect moves a stalled PC
    a_pc_held: assert property (
        @(posedge clk) disable iff (rst_i)
        (stall_i && !branch_flush_i && !redirect_valid_i) |=> $stable(pc1_i)
    ) else begin
        assert_fired = 1'b1;
        $error("pc1_o moved during a stall");
    end

    ////////////////////////////////
    // Buffer occupancy
    ////////////////////////////////

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst_i)
        count_i <= CNT_W'(IB_DEPTH)
    ) else begin
        assert_fired = 1'b1;
        $error("buffer count above depth");
    end

    a_head_order: assert property (
        @(posedge clk) disable iff (rst_i)
        head_valid_2_i |-> head_valid_1_i
    ) else begin
        assert_fired = 1'b1;
        $error("slot_2 valid without slot_1 valid");
    end

endmodule

bind frontend_top frontend_sva #(
    .IB_DEPTH (IB_DEPTH)
) u_frontend_sva (
    .clk              (clk),
    .rst_i            (rst_i),
    .stall_i          (stall_i),
    .branch_flush_i   (branch_flush_i),
    .redirect_valid_i (redirect.valid),
    .ib_room_i        (ib_room),
    .inst_en_1_i      (inst_en_1_o),
    .inst_en_2_i      (inst_en_2_o),
    .pc1_i            (pc1_o),
    .head_valid_1_i   (inst_and_pc_o.slot_1.valid),
    .head_valid_2_i   (inst_and_pc_o.slot_2.valid),
    .count_i          (u_instbuffer.count_q)
);

`default_nettype wire

// ==== verilog/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter frontend_pkg::addr_t RESET_PC = 32'h0000_1000,
    parameter int unsigned         IB_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       stall_i,
    input  logic                       branch_flush_i,
    input  frontend_pkg::addr_t        branch_actual_addr_i,

    // Instruction memory
    input  frontend_pkg::word_t        inst_1_i,
    input  frontend_pkg::word_t        inst_2_i,
    output logic                       inst_en_1_o,
    output logic                       inst_en_2_o,
    output frontend_pkg::addr_t        pc1_o,
    output frontend_pkg::addr_t        pc2_o,

    // Decode side
    input  logic                       send_inst_1_en_i,
    input  logic                       send_inst_2_en_i,
    output frontend_pkg::branch_info_t branch_info1_o,
    output frontend_pkg::branch_info_t branch_info2_o,
    output frontend_pkg::inst_and_pc_t inst_and_pc_o
);

    import frontend_pkg::*;

    fetch_req_t fetch;
    redirect_t  redirect;
    ib_slot_t   wr_slot_1;
    ib_slot_t   wr_slot_2;
    logic       ib_room;

    assign pc1_o       = fetch.pc_1;
    assign pc2_o       = fetch.pc_2;
    assign inst_en_1_o = fetch.en_1;
    assign inst_en_2_o = fetch.en_2;

    assign branch_info1_o = inst_and_pc_o.slot_1.info;
    assign branch_info2_o = inst_and_pc_o.slot_2.info;

    ////////////////////////////////
    // Blocks
    ////////////////////////////////

    pc_reg #(
        .RESET_PC (RESET_PC)
    ) u_pc_reg (
        .clk,
        .rst_i,
        .stall_i,
        .branch_flush_i,
        .branch_actual_addr_i,
        .redirect_i (redirect),
        .ib_room_i  (ib_room),
        .fetch_o    (fetch)
    );

    bpu u_bpu (
        .clk,
        .rst_i,
        .branch_flush_i,
        .fetch_i     (fetch),
        .inst_1_i,
        .inst_2_i,
        .redirect_o  (redirect),
        .wr_slot_1_o (wr_slot_1),
        .wr_slot_2_o (wr_slot_2)
    );

    instbuffer #(
        .IB_DEPTH (IB_DEPTH)
    ) u_instbuffer (
        .clk,
        .rst_i,
        .branch_flush_i,
        .wr_slot_1_i (wr_slot_1),
        .wr_slot_2_i (wr_slot_2),
        .send_inst_1_en_i,
        .send_inst_2_en_i,
        .ib_room_o   (ib_room),
        .inst_and_pc_o
    );

endmodule

`default_nettype wire

// ==== verilog/instbuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instbuffer #(
    parameter int unsigned IB_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       branch_flush_i,
    input  frontend_pkg::ib_slot_t     wr_slot_1_i,
    input  frontend_pkg::ib_slot_t     wr_slot_2_i,
    input  logic                       send_inst_1_en_i,
    input  logic                       send_inst_2_en_i,
    output logic                       ib_room_o,
    output frontend_pkg::inst_and_pc_t inst_and_pc_o
);

    import frontend_pkg::*;

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    ib_slot_t mem_q [IB_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic [PTR_W-1:0] wr_idx_2;
    logic [PTR_W-1:0] rd_idx_2;
    logic             pop_1;
    logic             pop_2;
    logic [1:0]       wr_n;
    logic [1:0]       pop_n;

    ////////////////////////////////
    // Write side
    ////////////////////////////////

    // Second write lands right after the first one
    assign wr_idx_2 = tail_q + PTR_W'(wr_slot_1_i.valid);
    assign wr_n     = 2'(wr_slot_1_i.valid) + 2'(wr_slot_2_i.valid);

    always_ff @(posedge clk) begin
        if (!branch_flush_i) begin
            if (wr_slot_1_i.valid) begin
                mem_q[tail_q] <= wr_slot_1_i;
            end
            if (wr_slot_2_i.valid) begin
                mem_q[wr_idx_2] <= wr_slot_2_i;
            end
        end
    end

    ////////////////////////////////
    // Read side
    ////////////////////////////////

    // Never pop past what is held
    assign pop_1 = send_inst_1_en_i & (count_q >= CNT_W'(1));
    assign pop_2 = pop_1 & send_inst_2_en_i & (count_q >= CNT_W'(2));
    assign pop_n = 2'(pop_1) + 2'(pop_2);

    always_ff @(posedge clk) begin
        if (rst_i || branch_flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(pop_n);
            tail_q  <= tail_q + PTR_W'(wr_n);
            count_q <= count_q + CNT_W'(wr_n) - CNT_W'(pop_n);
        end
    end

    assign rd_idx_2 = head_q + PTR_W'(1);

    // Head entries with valid taken from the count
    always_comb begin
        inst_and_pc_o.slot_1       = mem_q[head_q];
        inst_and_pc_o.slot_1.valid = (count_q >= CNT_W'(1));
        inst_and_pc_o.slot_2       = mem_q[rd_idx_2];
        inst_and_pc_o.slot_2.valid = (count_q >= CNT_W'(2));
    end

    // Four free entries cover the pair being written and the pair in flight
    assign ib_room_o = (count_q <= CNT_W'(IB_DEPTH - 4));

endmodule

`default_nettype wire

// ==== verilog/bpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     branch_flush_i,
    input  frontend_pkg::fetch_req_t fetch_i,
    input  frontend_pkg::word_t      inst_1_i,
    input  frontend_pkg::word_t      inst_2_i,
    output frontend_pkg::redirect_t  redirect_o,
    output frontend_pkg::ib_slot_t   wr_slot_1_o,
    output frontend_pkg::ib_slot_t   wr_slot_2_o
);

    import frontend_pkg::*;

    // Fetch PCs delayed to line up with the returning words
    addr_t pc_1_q;
    addr_t pc_2_q;
    logic  en_1_q;
    logic  en_2_q;

    // Pair fetched during a redirect cycle is wrong path
    logic  squash_q;

    branch_info_t info_1;
    branch_info_t info_2;
    logic         vld_1;
    logic         vld_2;

    // Static prediction on a single word
    function automatic branch_info_t predecode(input addr_t pc, input word_t inst);
        opcode_t      opcode;
        addr_t        imm_b;
        addr_t        imm_j;
        branch_info_t info;
        opcode = inst[OPC_W-1:0];
        imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        info   = '0;
        if (opcode == OPC_JAL) begin
            info.is_branch = 1'b1;
            info.taken     = 1'b1;
            info.target    = pc + imm_j;
        end else if (opcode == OPC_BRANCH) begin
            // Backward taken, forward not taken
            info.is_branch = 1'b1;
            info.taken     = inst[31];
            info.target    = pc + imm_b;
        end
        // Target stays zero for everything else
        return info;
    endfunction

    ////////////////////////////////
    // Request pipeline
    ////////////////////////////////

    always_ff @(posedge clk) begin
        pc_1_q <= fetch_i.pc_1;
        pc_2_q <= fetch_i.pc_2;
    end

    always_ff @(posedge clk) begin
        if (rst_i || branch_flush_i) begin
            en_1_q   <= 1'b0;
            en_2_q   <= 1'b0;
            squash_q <= 1'b0;
        end else begin
            en_1_q   <= fetch_i.en_1;
            en_2_q   <= fetch_i.en_2;
            squash_q <= redirect_o.valid;
        end
    end

    ////////////////////////////////
    // Predecode and slot survival
    ////////////////////////////////

    assign info_1 = predecode(pc_1_q, inst_1_i);
    assign info_2 = predecode(pc_2_q, inst_2_i);

    // Slot 2 dies behind a taken slot 1
    assign vld_1 = en_1_q & ~squash_q;
    assign vld_2 = en_2_q & vld_1 & ~info_1.taken;

    always_comb begin
        redirect_o = '0;
        if (vld_1 && info_1.taken) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = info_1.target;
        end else if (vld_2 && info_2.taken) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = info_2.target;
        end
    end

    always_comb begin
        wr_slot_1_o.valid = vld_1;
        wr_slot_1_o.pc    = pc_1_q;
        wr_slot_1_o.inst  = inst_1_i;
        wr_slot_1_o.info  = info_1;

        wr_slot_2_o.valid = vld_2;
        wr_slot_2_o.pc    = pc_2_q;
        wr_slot_2_o.inst  = inst_2_i;
        wr_slot_2_o.info  = info_2;
    end

endmodule

`default_nettype wire

// ==== verilog/pc_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_reg #(
    parameter frontend_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     stall_i,
    input  logic                     branch_flush_i,
    input  frontend_pkg::addr_t      branch_actual_addr_i,
    input  frontend_pkg::redirect_t  redirect_i,
    input  logic                     ib_room_i,
    output frontend_pkg::fetch_req_t fetch_o
);

    import frontend_pkg::*;

    addr_t pc_q;
    addr_t pc_d;
    logic  run_q;
    logic  fetch_en;

    // Fetch only once out of reset, not stalled, and with room downstream
    assign fetch_en = run_q & ~stall_i & ib_room_i;

    ////////////////////////////////
    // Next PC
    ////////////////////////////////

    always_comb begin
        if (branch_flush_i) begin
            // Backend misprediction wins over everything
            pc_d = branch_actual_addr_i;
        end else if (redirect_i.valid) begin
            pc_d = redirect_i.target;
        end else if (fetch_en) begin
            pc_d = pc_q + addr_t'(8);
        end else begin
            // Stall or full buffer
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q  <= RESET_PC;
            run_q <= 1'b0;
        end else begin
            pc_q  <= pc_d;
            run_q <= 1'b1;
        end
    end

    ////////////////////////////////
    // Request to memory and bpu
    ////////////////////////////////

    always_comb begin
        fetch_o.pc_1 = pc_q;
        fetch_o.pc_2 = pc_q + addr_t'(4);
        fetch_o.en_1 = fetch_en;
        fetch_o.en_2 = fetch_en;
    end

endmodule

`default_nettype wire

// ==== verilog/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    ////////////////////////////////
    // Widths
    ////////////////////////////////

    localparam int XLEN  = 32;
    localparam int OPC_W = 7;

    typedef logic [XLEN-1:0]  addr_t;
    typedef logic [XLEN-1:0]  word_t;
    typedef logic [OPC_W-1:0] opcode_t;

    // Control transfer opcodes seen by predecode
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    ////////////////////////////////
    // Fetch side
    ////////////////////////////////

    // One fetch pair where pc_2 is always pc_1 plus 4
    typedef struct packed {
        addr_t pc_1;
        addr_t pc_2;
        logic  en_1;
        logic  en_2;
    } fetch_req_t;

    // Predicted-taken redirect back to the PC
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    ////////////////////////////////
    // Buffer side
    ////////////////////////////////

    // Prediction facts per slot in 34 bits
    typedef struct packed {
        logic  is_branch;
        logic  taken;
        addr_t target;
    } branch_info_t;

    typedef struct packed {
        logic         valid;
        addr_t        pc;
        word_t        inst;
        branch_info_t info;
    } ib_slot_t;

    // Two oldest buffer entries with slot_1 first
    typedef struct packed {
        ib_slot_t slot_1;
        ib_slot_t slot_2;
    } inst_and_pc_t;

endpackage

`default_nettype wire
